/* build.f */
+incdir+design
design/sonata_pkg.sv
design/reg_bus_if.sv
design/bus_decoder.sv
design/pwm_channel.sv
design/gpio_regs.sv
design/rsp_mux.sv
design/sonata_system.sv
verification/tb_sonata_system.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log build.log

verilator --binary --timing -Wno-fatal \
  -f build.f --top-module tb_sonata_system \
  > build.log 2>&1 \
  && ./obj_dir/Vtb_sonata_system > sim.log 2>&1 \
  || echo "build or simulation ended with an error, see build.log and sim.log"

grep -qx "test passed" sim.log 2>/dev/null \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }

/* verification/tb_sonata_system.sv */
`timescale 1ns/1ns
`include "sonata_params.svh"

module tb_sonata_system import sonata_pkg::*; ();

  typedef enum logic [1:0] {
    OpIdle,
    OpRead,
    OpWrite
  } op_e;

  // One bus cycle and the response expected one cycle later
  typedef struct packed {
    op_e                   op;
    bus_addr_t             addr;
    bus_data_t             wdata;
    bus_be_t               be;
    bus_data_t             exp_rdata;
    logic                  exp_err;
    logic [`GPO_WIDTH-1:0] exp_gpo;  // gp_o once this row has taken effect
  } row_t;

  logic                  clk_sys;
  logic                  arst_n;
  logic                  req;
  logic                  we;
  bus_be_t               be;
  bus_addr_t             addr;
  bus_data_t             wdata;
  logic                  rvalid;
  bus_data_t             rdata;
  logic                  err;
  logic [`GPI_WIDTH-1:0] gp_in;
  logic [`GPO_WIDTH-1:0] gp_out;
  logic [`PWM_NUM-1:0]   pwm;

  row_t                  rows [128];
  int                    n_rows;
  logic [31:0]           seed;
  logic [`GPO_WIDTH-1:0] gpo_model;
  pwm_cfg_t              cfg_model [`PWM_NUM];
  int                    n_checks;
  int                    n_errors;
  longint                limit_ns;

  sonata_system i_dut (
    .clk_sys_i(clk_sys),
    .arst_n_i (arst_n),
    .req_i    (req),
    .we_i     (we),
    .be_i     (be),
    .addr_i   (addr),
    .wdata_i  (wdata),
    .rvalid_o (rvalid),
    .rdata_o  (rdata),
    .err_o    (err),
    .gp_i     (gp_in),
    .gp_o     (gp_out),
    .pwm_o    (pwm)
  );

  initial begin
    clk_sys = 1'b0;
    forever #4 clk_sys = ~clk_sys;
  end

  // Ends a run that stalls
  initial begin
    wait (limit_ns > 0);
    #(limit_ns);
    $display("watchdog expired, the run did not finish in time");
    $display("test failed");
    $finish;
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic next_random(output logic [31:0] r);
    seed = lcg_step(seed);
    r = {seed[15:0], seed[31:16]};  // High bits are the better ones
  endtask

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
  endtask

  // Bus word of one channel, period in bits 15:8 and width in bits 7:0
  function automatic bus_data_t cfg_word(input int ch);
    return {16'b0, cfg_model[ch].period, cfg_model[ch].width};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////////////////////////////////////////

  task automatic add_row(input op_e op, input bus_addr_t a, input bus_data_t w,
                         input bus_be_t b, input bus_data_t exp_r, input logic exp_e);
    rows[n_rows] = '{op, a, w, b, exp_r, exp_e, gpo_model};
    n_rows++;
  endtask

  task automatic write_gpo(input bus_data_t w, input bus_be_t b);
    for (int i = 0; i < `GPO_WIDTH / 8; i++) begin
      if (b[i]) gpo_model[i*8 +: 8] = w[i*8 +: 8];  // Byte 3 has no register
    end
    add_row(OpWrite, `GPIO_BASE, w, b, '0, 1'b0);
  endtask

  task automatic write_pwm(input int ch, input bus_data_t w, input bus_be_t b);
    if (b[0]) cfg_model[ch].width = w[7:0];
    if (b[1]) cfg_model[ch].period = w[15:8];
    add_row(OpWrite, `PWM_BASE + 4 * ch, w, b, '0, 1'b0);
  endtask

  task automatic read_back(input bus_addr_t a, input bus_data_t exp_r);
    add_row(OpRead, a, '0, 4'hF, exp_r, 1'b0);
  endtask

  // Error responses read as zero whatever the operation
  task automatic bad_access(input op_e op, input bus_addr_t a);
    logic [31:0] w;
    next_random(w);
    add_row(op, a, w, 4'hF, '0, 1'b1);
  endtask

  task automatic build_table();
    logic [31:0] r;
    bus_addr_t   bad_addrs [9];
    bad_addrs = '{32'h0000_0008, 32'h0000_00FC, 32'h0000_0002, 32'h0000_0105,
                  32'h0000_0130, 32'h0000_01FC, 32'h0000_0200, 32'h1000_0000,
                  32'h8000_0104};
    n_rows = 0;
    next_random(r);
    write_gpo(r, 4'hF);
    read_back(`GPIO_BASE, bus_data_t'(gpo_model));
    next_random(r);
    write_gpo(r, 4'b0101);
    next_random(r);
    write_gpo(r, 4'b1010);
    read_back(`GPIO_BASE, bus_data_t'(gpo_model));
    add_row(OpIdle, '0, '0, '0, '0, 1'b0);
    next_random(r);
    write_gpo(r, 4'b0000);
    read_back(`GPIO_BASE, bus_data_t'(gpo_model));
    // GPI is read only
    read_back(`GPIO_BASE + 4, bus_data_t'(gp_in));
    next_random(r);
    add_row(OpWrite, `GPIO_BASE + 4, r, 4'hF, '0, 1'b0);
    read_back(`GPIO_BASE + 4, bus_data_t'(gp_in));
    read_back(`GPIO_BASE, bus_data_t'(gpo_model));
    for (int ch = 0; ch < `PWM_NUM; ch++) begin
      next_random(r);
      write_pwm(ch, r, 4'b0011);
    end
    next_random(r);
    write_pwm(5, r, 4'b0010);  // Period only
    next_random(r);
    write_pwm(9, r, 4'b0001);  // Width only
    for (int ch = 0; ch < `PWM_NUM; ch++) begin
      read_back(`PWM_BASE + 4 * ch, cfg_word(ch));
    end
    for (int i = 0; i < 9; i++) begin
      bad_access((i % 2 == 0) ? OpWrite : OpRead, bad_addrs[i]);
    end
    add_row(OpIdle, '0, '0, '0, '0, 1'b0);
    // Nothing moved after the bad accesses
    read_back(`GPIO_BASE, bus_data_t'(gpo_model));
    read_back(`GPIO_BASE + 4, bus_data_t'(gp_in));
    for (int ch = 0; ch < `PWM_NUM; ch++) begin
      read_back(`PWM_BASE + 4 * ch, cfg_word(ch));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Drive and check
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_response(input row_t row);
    compare_value("rvalid_o", {31'b0, rvalid}, {31'b0, row.op != OpIdle});
    if (row.op != OpIdle) compare_value("err_o", {31'b0, err}, {31'b0, row.exp_err});
    if (row.op == OpRead || row.exp_err) compare_value("rdata_o", rdata, row.exp_rdata);
    compare_value("gp_o", 32'(gp_out), 32'(row.exp_gpo));
  endtask

  // One row per cycle, so requests run back to back
  task automatic apply_rows();
    for (int r = 0; r <= n_rows; r++) begin
      @(negedge clk_sys);
      if (r > 0) check_response(rows[r-1]);
      req   = (r < n_rows) && (rows[r].op != OpIdle);
      we    = (r < n_rows) && (rows[r].op == OpWrite);
      be    = (r < n_rows) ? rows[r].be : '0;
      addr  = (r < n_rows) ? rows[r].addr : '0;
      wdata = (r < n_rows) ? rows[r].wdata : '0;
    end
    @(negedge clk_sys);
    compare_value("rvalid_o", {31'b0, rvalid}, 32'd0);  // No request last cycle
  endtask

  // High time of every channel over its own window of period+1 cycles
  task automatic measure_pwm();
    int    win [`PWM_NUM];
    int    high [`PWM_NUM];
    int    max_win;
    int    exp;
    string name;
    max_win = 0;
    for (int ch = 0; ch < `PWM_NUM; ch++) begin
      win[ch]  = int'(cfg_model[ch].period) + 1;
      high[ch] = 0;
      if (win[ch] > max_win) max_win = win[ch];
    end
    for (int c = 0; c < max_win; c++) begin
      @(negedge clk_sys);
      for (int ch = 0; ch < `PWM_NUM; ch++) begin
        if (c < win[ch] && pwm[ch]) high[ch]++;
      end
    end
    for (int ch = 0; ch < `PWM_NUM; ch++) begin
      exp  = (int'(cfg_model[ch].width) < win[ch]) ? int'(cfg_model[ch].width) : win[ch];
      name = $sformatf("pwm_o[%0d] high cycles", ch);
      compare_value(name, high[ch], exp);
    end
  endtask

  initial begin
    logic [31:0] r;
    int          total_win;
    seed     = 32'd53483;
    n_checks = 0;
    n_errors = 0;
    limit_ns = 0;
    arst_n   = 1'b0;
    req      = 1'b0;
    we       = 1'b0;
    be       = '0;
    addr     = '0;
    wdata    = '0;
    next_random(r);
    gp_in     = r[`GPI_WIDTH-1:0];
    gpo_model = '0;
    for (int ch = 0; ch < `PWM_NUM; ch++) cfg_model[ch] = '0;
    build_table();
    total_win = 0;
    for (int ch = 0; ch < `PWM_NUM; ch++) total_win += int'(cfg_model[ch].period) + 1;
    limit_ns = (n_rows * 4 + total_win + 100) * 8;

    repeat (3) @(posedge clk_sys);
    @(negedge clk_sys);
    compare_value("gp_o", 32'(gp_out), 32'd0);
    compare_value("pwm_o", 32'(pwm), 32'd0);
    compare_value("rvalid_o", {31'b0, rvalid}, 32'd0);
    compare_value("err_o", {31'b0, err}, 32'd0);
    arst_n = 1'b1;
    repeat (4) @(negedge clk_sys);  // gp_i through the synchroniser

    apply_rows();
    measure_pwm();

    $display("%0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) $display("test passed");
    else $display("test failed");
    $finish;
  end

endmodule

/* design/sonata_system.sv */
`timescale 1ns/1ns
`include "sonata_params.svh"

module sonata_system import sonata_pkg::*; (
  input  logic                  clk_sys_i,
  input  logic                  arst_n_i,

  // Register bus
  input  logic                  req_i,
  input  logic                  we_i,
  input  bus_be_t               be_i,
  input  bus_addr_t             addr_i,
  input  bus_data_t             wdata_i,
  output logic                  rvalid_o,
  output bus_data_t             rdata_o,
  output logic                  err_o,

  // Pads
  input  logic [`GPI_WIDTH-1:0] gp_i,
  output logic [`GPO_WIDTH-1:0] gp_o,
  output logic [`PWM_NUM-1:0]   pwm_o
);

  reg_bus_if gpio_bus ();
  reg_bus_if pwm_bus ();

  bus_device_e           dev_sel;
  reg_addr_t             offset;
  logic [`GPI_WIDTH-1:0] gpi_sync;
  pwm_cfg_t              pwm_cfg [`PWM_NUM];

  ////////////////////////////////////////////////////////////////////////////
  // Request side
  ////////////////////////////////////////////////////////////////////////////

  bus_decoder u_bus_decoder (
    .req_i    (req_i),
    .we_i     (we_i),
    .be_i     (be_i),
    .addr_i   (addr_i),
    .wdata_i  (wdata_i),
    .gpio_bus (gpio_bus),
    .pwm_bus  (pwm_bus),
    .dev_sel_o(dev_sel),
    .offset_o (offset)
  );

  gpio_regs u_gpio_regs (
    .clk_sys_i (clk_sys_i),
    .arst_n_i  (arst_n_i),
    .bus       (gpio_bus),
    .gp_i      (gp_i),
    .gp_o      (gp_o),
    .gpi_sync_o(gpi_sync)
  );

  // All channels share one bus, each matches its own offset
  for (genvar i = 0; i < `PWM_NUM; i++) begin : gen_pwm
    pwm_channel #(
      .CHAN_IDX(i)
    ) u_pwm_channel (
      .clk_sys_i(clk_sys_i),
      .arst_n_i (arst_n_i),
      .bus      (pwm_bus),
      .cfg_o    (pwm_cfg[i]),
      .pwm_o    (pwm_o[i])
    );
  end : gen_pwm

  ////////////////////////////////////////////////////////////////////////////
  // Response side
  ////////////////////////////////////////////////////////////////////////////

  rsp_mux u_rsp_mux (
    .clk_sys_i(clk_sys_i),
    .arst_n_i (arst_n_i),
    .req_i    (req_i),
    .dev_sel_i(dev_sel),
    .offset_i (offset),
    .gpo_i    (gp_o),
    .gpi_i    (gpi_sync),
    .pwm_cfg_i(pwm_cfg),
    .rvalid_o (rvalid_o),
    .rdata_o  (rdata_o),
    .err_o    (err_o)
  );

endmodule

/* design/rsp_mux.sv */
`timescale 1ns/1ns
`include "sonata_params.svh"

module rsp_mux import sonata_pkg::*; (
  input  logic                  clk_sys_i,
  input  logic                  arst_n_i,
  input  logic                  req_i,
  input  bus_device_e           dev_sel_i,
  input  reg_addr_t             offset_i,
  input  logic [`GPO_WIDTH-1:0] gpo_i,
  input  logic [`GPI_WIDTH-1:0] gpi_i,
  input  pwm_cfg_t              pwm_cfg_i [`PWM_NUM],
  output logic                  rvalid_o,
  output bus_data_t             rdata_o,
  output logic                  err_o
);

  logic [`REG_ADDR_WIDTH-3:0] pwm_idx;
  bus_data_t                  rdata_d;
  logic                       rvalid_q;
  logic                       err_q;
  bus_data_t                  rdata_q;

  assign pwm_idx = offset_i[`REG_ADDR_WIDTH-1:2];

  // Read data from register values before this cycle's write
  always_comb begin
    rdata_d = '0;
    case (dev_sel_i)
      DevGpio: begin
        if (offset_i == GpoReg) rdata_d = bus_data_t'(gpo_i);
        else rdata_d = bus_data_t'(gpi_i);
      end
      DevPwm: begin
        for (int i = 0; i < `PWM_NUM; i++) begin
          if (pwm_idx == i) rdata_d = bus_data_t'(pwm_cfg_i[i]);
        end
      end
      default: rdata_d = '0;  // Errors read as zero
    endcase
  end

  always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      rvalid_q <= req_i;
      err_q    <= req_i && (dev_sel_i == DevNone);
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (req_i) rdata_q <= rdata_d;
  end

  assign rvalid_o = rvalid_q;
  assign err_o    = err_q;
  assign rdata_o  = rdata_q;

endmodule

/* design/gpio_regs.sv */
`timescale 1ns/1ns
`include "sonata_params.svh"

module gpio_regs import sonata_pkg::*; (
  input  logic                  clk_sys_i,
  input  logic                  arst_n_i,
  reg_bus_if.device             bus,
  input  logic [`GPI_WIDTH-1:0] gp_i,
  output logic [`GPO_WIDTH-1:0] gp_o,
  output logic [`GPI_WIDTH-1:0] gpi_sync_o
);

  logic [`GPO_WIDTH-1:0] gpo_q;
  logic [`GPI_WIDTH-1:0] gpi_meta_q;
  logic [`GPI_WIDTH-1:0] gpi_sync_q;
  logic [`GPO_WIDTH-1:0] be_mask;
  logic                  gpo_we;

  // Expand byte enables to a bit mask
  always_comb begin
    for (int b = 0; b < `GPO_WIDTH / 8; b++) begin
      be_mask[b*8 +: 8] = {8{bus.be[b]}};
    end
  end

  // Writes to GpiReg fall through here
  assign gpo_we = bus.req && bus.we && (bus.offset == GpoReg);

  always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      gpo_q <= '0;
    end else if (gpo_we) begin
      gpo_q <= (gpo_q & ~be_mask) | (bus.wdata[`GPO_WIDTH-1:0] & be_mask);
    end
  end

  assign gp_o = gpo_q;

  // Two flop synchroniser for the pads
  always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      gpi_meta_q <= '0;
      gpi_sync_q <= '0;
    end else begin
      gpi_meta_q <= gp_i;
      gpi_sync_q <= gpi_meta_q;
    end
  end

  assign gpi_sync_o = gpi_sync_q;

endmodule

/* design/pwm_channel.sv */
`timescale 1ns/1ns
`include "sonata_params.svh"

module pwm_channel import sonata_pkg::*; #(
  parameter int unsigned CHAN_IDX = 0
) (
  input  logic      clk_sys_i,
  input  logic      arst_n_i,
  reg_bus_if.device bus,
  output pwm_cfg_t  cfg_o,
  output logic      pwm_o
);

  localparam reg_addr_t ChanOffset = reg_addr_t'(CHAN_IDX * 4);

  pwm_cfg_t cfg_q;
  pwm_ctr_t ctr_q;
  logic     cfg_we;

  assign cfg_we = bus.req && bus.we && (bus.offset == ChanOffset);

  ////////////////////////////////////////////////////////////////////////////
  // Configuration register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cfg_q <= '0;
    end else if (cfg_we) begin
      if (bus.be[0]) cfg_q.width <= bus.wdata[`PWM_CTR_SIZE-1:0];
      if (bus.be[1]) begin
        cfg_q.period <= bus.wdata[2*`PWM_CTR_SIZE-1:`PWM_CTR_SIZE];
      end
    end
  end

  assign cfg_o = cfg_q;

  ////////////////////////////////////////////////////////////////////////////
  // Counter and compare
  ////////////////////////////////////////////////////////////////////////////

  // Counts 0..period, so one PWM cycle is period+1 clocks
  always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ctr_q <= '0;
    end else if (cfg_we) begin
      ctr_q <= '0;  // Restart on any reconfiguration
    end else if (ctr_q >= cfg_q.period) begin
      ctr_q <= '0;
    end else begin
      ctr_q <= ctr_q + 1'b1;
    end
  end

  assign pwm_o = (ctr_q < cfg_q.width);  // Width above period keeps output high

endmodule

/* design/bus_decoder.sv */
`timescale 1ns/1ns
`include "sonata_params.svh"

module bus_decoder import sonata_pkg::*; (
  input  logic        req_i,
  input  logic        we_i,
  input  bus_be_t     be_i,
  input  bus_addr_t   addr_i,
  input  bus_data_t   wdata_i,
  reg_bus_if.decoder  gpio_bus,
  reg_bus_if.decoder  pwm_bus,
  output bus_device_e dev_sel_o,
  output reg_addr_t   offset_o
);

  localparam bus_addr_t GpioBase = `GPIO_BASE;
  localparam bus_addr_t PwmBase  = `PWM_BASE;

  logic      aligned;
  logic      gpio_hit;
  logic      pwm_hit;
  reg_addr_t offset;

  assign offset  = addr_i[`REG_ADDR_WIDTH-1:0];
  assign aligned = (addr_i[1:0] == 2'b00);

  // Base match on the upper bits, then a per-device offset check
  assign gpio_hit = aligned &&
                    (addr_i[`BUS_ADDR_WIDTH-1:`REG_ADDR_WIDTH] ==
                     GpioBase[`BUS_ADDR_WIDTH-1:`REG_ADDR_WIDTH]) &&
                    ((offset == GpoReg) || (offset == GpiReg));

  assign pwm_hit = aligned &&
                   (addr_i[`BUS_ADDR_WIDTH-1:`REG_ADDR_WIDTH] ==
                    PwmBase[`BUS_ADDR_WIDTH-1:`REG_ADDR_WIDTH]) &&
                   (offset[`REG_ADDR_WIDTH-1:2] < `PWM_NUM); // One word per channel

  always_comb begin
    if (gpio_hit) dev_sel_o = DevGpio;
    else if (pwm_hit) dev_sel_o = DevPwm;
    else dev_sel_o = DevNone;
  end

  assign offset_o = offset;

  // Strobe only reaches the selected device
  assign gpio_bus.req    = req_i && (dev_sel_o == DevGpio);
  assign gpio_bus.we     = we_i;
  assign gpio_bus.be     = be_i;
  assign gpio_bus.offset = offset;
  assign gpio_bus.wdata  = wdata_i;

  assign pwm_bus.req    = req_i && (dev_sel_o == DevPwm);
  assign pwm_bus.we     = we_i;
  assign pwm_bus.be     = be_i;
  assign pwm_bus.offset = offset;
  assign pwm_bus.wdata  = wdata_i;

endmodule

/* design/reg_bus_if.sv */
`timescale 1ns/1ns

interface reg_bus_if import sonata_pkg::*; ();

  logic      req;    // Single cycle strobe
  logic      we;
  bus_be_t   be;
  reg_addr_t offset;
  bus_data_t wdata;

  modport decoder (
    output req,
    output we,
    output be,
    output offset,
    output wdata
  );

  modport device (
    input req,
    input we,
    input be,
    input offset,
    input wdata
  );

endinterface

/* design/sonata_pkg.sv */
`include "sonata_params.svh"

package sonata_pkg;

  // Bus payload types
  typedef logic [`BUS_ADDR_WIDTH-1:0] bus_addr_t;
  typedef logic [`BUS_DATA_WIDTH-1:0] bus_data_t;
  typedef logic [`BUS_BE_WIDTH-1:0]   bus_be_t;
  typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;

  typedef logic [`PWM_CTR_SIZE-1:0] pwm_ctr_t;

  // Packed as seen on the bus, period in the high byte
  typedef struct packed {
    pwm_ctr_t period;
    pwm_ctr_t width;
  } pwm_cfg_t;

  typedef enum logic [1:0] {
    DevGpio,
    DevPwm,
    DevNone  // Unmapped or misaligned
  } bus_device_e;

  typedef enum logic [`REG_ADDR_WIDTH-1:0] {
    GpoReg = 8'h00,
    GpiReg = 8'h04  // Read only
  } gpio_reg_e;

endpackage

/* design/sonata_params.svh */
`ifndef SONATA_PARAMS_SVH
`define SONATA_PARAMS_SVH

// General purpose IO
`define GPI_WIDTH 13
`define GPO_WIDTH 24

// PWM bank
`define PWM_NUM      12
`define PWM_CTR_SIZE 8

// Register bus
`define BUS_ADDR_WIDTH 32
`define BUS_DATA_WIDTH 32
`define BUS_BE_WIDTH   4
`define REG_ADDR_WIDTH 8  // Offset within one device

////////////////////////////////////////////////////////////////////////////
// Address map
////////////////////////////////////////////////////////////////////////////

`define GPIO_BASE 32'h0000_0000
`define PWM_BASE  32'h0000_0100

`endif
